/* Makefile */
# Verilator flow for the memory self-test.
VERILATOR ?= verilator
TOP       ?= memtest_tb
FLIST     ?= build.f
MDIR      ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASSTEXT  ?= TB PASSED
SIM       := $(MDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FLIST)

# the run passes only if the pass line shows up in the output.
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(MDIR)

/* bench/memtest_checker.sv */
`timescale 1ns/10ps
// ~~~~~~~~~~~~~~~~~~~~
// wishbone protocol and done/busy assertions.
// bound to the self-test top level.
// ~~~~~~~~~~~~~~~~~~~~

module memtest_checker
(
	input  logic iCLK,
	input  logic iRST,
	wbBus.monitor wb,
	input  logic busy,
	input  logic done
);

int unsigned violations = 0;		// read by the testbench at the end.

aStbCyc: assert property (@(posedge iCLK) disable iff (iRST) wb.stb |-> wb.cyc)
	else begin $error("stb high without cyc"); violations++; end

// master holds the request until ack.
aHold: assert property (@(posedge iCLK) disable iff (iRST)
	(wb.stb && !wb.ack) |=> ($stable(wb.adr) && $stable(wb.we) && $stable(wb.datW)))
	else begin $error("request changed before ack"); violations++; end

aAckStb: assert property (@(posedge iCLK) disable iff (iRST) wb.ack |-> wb.stb)
	else begin $error("ack without stb"); violations++; end

aAckOnce: assert property (@(posedge iCLK) disable iff (iRST) wb.ack |=> !wb.ack)
	else begin $error("ack high for two cycles"); violations++; end

aDoneBusy: assert property (@(posedge iCLK) disable iff (iRST)
	done |-> (!busy && $past(busy)))
	else begin $error("busy did not fall with done"); violations++; end

endmodule

bind memtest_top memtest_checker chk0 (
	.iCLK (iCLK),
	.iRST (iRST),
	.wb   (wb0.monitor),
	.busy (busy),
	.done (done)
);

/* bench/memtest_tb.sv */
`timescale 1ns/10ps
// ~~~~~~~~~~~~~~~~~~~~
// memory self-test testbench.
// stimulus, reference model, comparator and timeout.
// ~~~~~~~~~~~~~~~~~~~~
`include "memtest_params.svh"

module memtest_tb
	import memtest_pkg::*;
();

typedef logic [`MT_ERRCNT_WIDTH-1:0] errCountType;

typedef struct packed {
	logic        errFlag;
	errCountType count;
	memAdrs      adrs;
	memWord      data;
} expResult;

// a transfer takes wait states plus four cycles, a run is two passes.
localparam int cyclesPerRun = 2 * (1 << `MT_ADRS_WIDTH) * (`MT_WAIT_STATES + 4) + 8;
localparam int runCount = 9;
localparam int timeoutCycles = runCount * cyclesPerRun + 1016;	// reset and margin.

logic iCLK;
logic iRST;
logic start;
memWord patternBase;
logic faultEn;
memAdrs faultAdrs;
memWord faultMask;
logic busy;
logic done;
logic error;
errCountType errCount;
memAdrs firstErrAdrs;
memWord firstErrData;

expResult expQ[$];
string nameQ[$];
int valueErrors = 0;
int otherErrors = 0;
int startCnt = 0;
int doneCnt = 0;
int cycleCnt = 0;

memtest_top dut0 (
	.iCLK         (iCLK),
	.iRST         (iRST),
	.start        (start),
	.patternBase  (patternBase),
	.faultEn      (faultEn),
	.faultAdrs    (faultAdrs),
	.faultMask    (faultMask),
	.busy         (busy),
	.done         (done),
	.error        (error),
	.errCount     (errCount),
	.firstErrAdrs (firstErrAdrs),
	.firstErrData (firstErrData)
);

initial
begin
	iCLK = 1'b0;
	forever #2 iCLK = ~iCLK;
end

// ~~~~~~~~~~~~~~~~~~~~
// reference model
// ~~~~~~~~~~~~~~~~~~~~
// only the faulty cell can miscompare, and only if the mask flips a bit.
function automatic expResult predict(memWord base, logic fEn, memAdrs fAdrs, memWord fMask);
	expResult r;
	memWord good;
	good = base + memWord'(fAdrs);
	r = '0;
	if (fEn && (fMask != '0))
	begin
		r.errFlag = 1'b1;
		r.count = errCountType'(1);
		r.adrs = fAdrs;
		r.data = good ^ fMask;		// the word read back.
	end
	return r;
endfunction

function automatic memWord nonzeroMask();
	memWord m;
	do
		m = memWord'($urandom);
	while (m == '0);
	return m;
endfunction

task automatic checkValue(string testName, string field, logic [31:0] want, logic [31:0] got);
	assert (got == want)
	else
	begin
		$display("Fail %s %s expected 'h%0h actual 'h%0h", testName, field, want, got);
		valueErrors++;
	end
endtask

task automatic startRun(string testName, memWord base, logic fEn, memAdrs fAdrs, memWord fMask);
	@(posedge iCLK);
	patternBase <= base;
	faultEn <= fEn;
	faultAdrs <= fAdrs;
	faultMask <= fMask;
	start <= 1'b1;
	expQ.push_back(predict(base, fEn, fAdrs, fMask));
	nameQ.push_back(testName);
	startCnt++;
	@(posedge iCLK);
	start <= 1'b0;
endtask

task automatic waitDone();
	do
		@(negedge iCLK);
	while (!done);
endtask

task automatic runTest(string testName, memWord base, logic fEn, memAdrs fAdrs, memWord fMask);
	startRun(testName, base, fEn, fAdrs, fMask);
	waitDone();
endtask

// ~~~~~~~~~~~~~~~~~~~~
// comparator
// ~~~~~~~~~~~~~~~~~~~~
initial
begin
	expResult want;
	string name;
	forever
	begin
		@(negedge iCLK);
		if (done)
		begin
			doneCnt++;
			assert (expQ.size() != 0)
			else
			begin
				$display("done pulsed although no run was started");
				otherErrors++;
			end
			if (expQ.size() != 0)
			begin
				want = expQ.pop_front();
				name = nameQ.pop_front();
				checkValue(name, "error", 32'(want.errFlag), 32'(error));
				checkValue(name, "errCount", 32'(want.count), 32'(errCount));
				checkValue(name, "firstErrAdrs", 32'(want.adrs), 32'(firstErrAdrs));
				checkValue(name, "firstErrData", 32'(want.data), 32'(firstErrData));
			end
		end
	end
end

// ~~~~~~~~~~~~~~~~~~~~
// stimulus
// ~~~~~~~~~~~~~~~~~~~~
initial
begin
	memWord base;
	memAdrs adrs;
	void'($urandom(84477));
	iRST <= 1'b1;
	start <= 1'b0;
	patternBase <= '0;
	faultEn <= 1'b0;
	faultAdrs <= '0;
	faultMask <= '0;
	repeat (16) @(posedge iCLK);
	iRST <= 1'b0;

	runTest("clean", memWord'($urandom), 1'b0, memAdrs'($urandom), memWord'($urandom));
	runTest("fault", memWord'($urandom), 1'b1, memAdrs'($urandom), nonzeroMask());
	runTest("zero mask", memWord'($urandom), 1'b1, memAdrs'($urandom), '0);

	// log must clear at every start.
	runTest("b2b fault a", memWord'($urandom), 1'b1, memAdrs'($urandom), nonzeroMask());
	runTest("b2b clean", memWord'($urandom), 1'b0, memAdrs'($urandom), nonzeroMask());
	runTest("b2b fault b", memWord'($urandom), 1'b1, memAdrs'($urandom), nonzeroMask());

	// second start mid-run with another base, results follow the first.
	base = memWord'($urandom);
	adrs = memAdrs'($urandom);
	startRun("start while busy", base, 1'b1, adrs, nonzeroMask());
	do
		@(negedge iCLK);
	while (!busy);
	repeat (3) @(posedge iCLK);
	patternBase <= ~base;
	start <= 1'b1;
	@(posedge iCLK);
	start <= 1'b0;
	waitDone();
	repeat (2) @(negedge iCLK);
	assert (!busy)
	else
	begin
		$display("a start given while busy launched a second run");
		otherErrors++;
	end

	runTest("fault at first", memWord'($urandom), 1'b1, '0, nonzeroMask());
	runTest("fault at last", memWord'($urandom), 1'b1, '1, nonzeroMask());

	@(negedge iCLK);
	assert (doneCnt == startCnt)
	else
	begin
		$display("%0d runs were started but %0d done pulses were seen", startCnt, doneCnt);
		otherErrors++;
	end
	$display("value errors %0d, other errors %0d, protocol errors %0d",
		valueErrors, otherErrors, dut0.chk0.violations);
	if ((valueErrors + otherErrors + dut0.chk0.violations) == 0)
		$display("TB PASSED");
	else
		$display("TB FAILED");
	$finish;
end

// ~~~~~~~~~~~~~~~~~~~~
// timeout
// ~~~~~~~~~~~~~~~~~~~~
initial
begin
	while (cycleCnt < timeoutCycles)
	begin
		@(posedge iCLK);
		cycleCnt++;
	end
	$display("timeout after %0d cycles, done never arrived", timeoutCycles);
	$display("TB FAILED");
	$finish;
end

endmodule

/* build.f */
+incdir+hdl
hdl/memtest_pkg.sv
hdl/memtest_if.sv
hdl/pattern_tester.sv
hdl/sram_controller.sv
hdl/sram_array.sv
hdl/memtest_top.sv
bench/memtest_checker.sv
bench/memtest_tb.sv

/* hdl/memtest_if.sv */
`timescale 1ns/10ps
// ~~~~~~~~~~~~~~~~~~~~
// wishbone classic bus between tester and controller.
// storage port between controller and array.
// ~~~~~~~~~~~~~~~~~~~~

interface wbBus import memtest_pkg::*; ();

	logic   cyc;
	logic   stb;
	logic   we;
	memAdrs adr;
	memWord datW;		// master to slave.
	memWord datR;		// slave to master, valid with ack.
	logic   ack;

	modport master (
		output cyc, stb, we, adr, datW,
		input  datR, ack
	);

	modport slave (
		input  cyc, stb, we, adr, datW,
		output datR, ack
	);

	// passive view for protocol checks.
	modport monitor (
		input cyc, stb, we, adr, datW, datR, ack
	);

endinterface


interface sramPort import memtest_pkg::*; ();

	memOp   op;
	memAdrs adrs;
	memWord wd;
	memWord rd;		// one cycle after opRead.

	modport ctrl (
		output op, adrs, wd,
		input  rd
	);

	modport mem (
		input  op, adrs, wd,
		output rd
	);

endinterface

/* hdl/memtest_params.svh */
// ~~~~~~~~~~~~~~~~~~~~
// memory self-test sizes, wait states and reset values.
// ~~~~~~~~~~~~~~~~~~~~
`ifndef MEMTEST_PARAMS_SVH
`define MEMTEST_PARAMS_SVH

// word address and data word widths.
`define MT_ADRS_WIDTH 6
`define MT_DATA_WIDTH 16

// idle cycles between stb and the storage access.
`define MT_WAIT_STATES 2

// mismatch counter, one bit wider than the address so a full failure fits.
`define MT_ERRCNT_WIDTH (`MT_ADRS_WIDTH + 1)

`define MT_ADRS_RST {`MT_ADRS_WIDTH{1'b0}}
`define MT_DATA_RST {`MT_DATA_WIDTH{1'b0}}

`endif

/* hdl/memtest_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// shared types of the memory self-test.
// word and address types, state and opcode enums.
// ~~~~~~~~~~~~~~~~~~~~
`include "memtest_params.svh"

package memtest_pkg;

	typedef logic [`MT_DATA_WIDTH-1:0] memWord;
	typedef logic [`MT_ADRS_WIDTH-1:0] memAdrs;

	// ~~~~~~~~~~~~~~~~~~~~
	// state machines.
	// ~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [1:0] {
		stIdle  = 2'd0,
		stWrite = 2'd1,		// pattern write pass.
		stRead  = 2'd2,		// read back and compare pass.
		stDone  = 2'd3
	} testerState;

	typedef enum logic [1:0] {
		csIdle   = 2'd0,
		csWait   = 2'd1,
		csAccess = 2'd2,	// storage op issued here.
		csAck    = 2'd3
	} ctrlState;

	// storage port command.
	typedef enum logic [1:0] {
		opNop   = 2'd0,
		opRead  = 2'd1,
		opWrite = 2'd2
	} memOp;

endpackage

/* hdl/memtest_top.sv */
`timescale 1ns/10ps
// ~~~~~~~~~~~~~~~~~~~~
// memory self-test top level.
// tester, wishbone controller and storage array.
// ~~~~~~~~~~~~~~~~~~~~
`include "memtest_params.svh"

module memtest_top
	import memtest_pkg::*;
(
	input  logic iCLK,
	input  logic iRST,
	input  logic start,
	input  memWord patternBase,
	input  logic faultEn,
	input  memAdrs faultAdrs,
	input  memWord faultMask,
	output logic busy,
	output logic done,
	output logic error,
	output logic [`MT_ERRCNT_WIDTH-1:0] errCount,
	output memAdrs firstErrAdrs,
	output memWord firstErrData
);

wbBus wb0 ();		// tester to controller.
sramPort sp0 ();	// controller to array.

pattern_tester tester0 (
	.iCLK         (iCLK),
	.iRST         (iRST),
	.start        (start),
	.patternBase  (patternBase),
	.wb           (wb0.master),
	.busy         (busy),
	.done         (done),
	.error        (error),
	.errCount     (errCount),
	.firstErrAdrs (firstErrAdrs),
	.firstErrData (firstErrData)
);

sram_controller ctrl0 (
	.iCLK (iCLK),
	.iRST (iRST),
	.wb   (wb0.slave),
	.mem  (sp0.ctrl)
);

// fault hook comes straight from the top ports.
sram_array array0 (
	.iCLK      (iCLK),
	.mem       (sp0.mem),
	.faultEn   (faultEn),
	.faultAdrs (faultAdrs),
	.faultMask (faultMask)
);

endmodule

/* hdl/pattern_tester.sv */
`timescale 1ns/10ps
// ~~~~~~~~~~~~~~~~~~~~
// write-then-verify memory tester.
// wishbone master, comparator and first-error log.
// ~~~~~~~~~~~~~~~~~~~~
`include "memtest_params.svh"

module pattern_tester
	import memtest_pkg::*;
(
	input  logic iCLK,
	input  logic iRST,
	input  logic start,
	input  memWord patternBase,
	wbBus.master wb,
	output logic busy,
	output logic done,
	output logic error,
	output logic [`MT_ERRCNT_WIDTH-1:0] errCount,
	output memAdrs firstErrAdrs,
	output memWord firstErrData
);

testerState rState;
memAdrs rAdrs;
memWord rBase;
logic rStb;

logic qAccept;
logic qLastAdrs;
logic qReadAck;
memWord qPattern;

assign qAccept = (rState == stIdle) && start;		// start is ignored outside idle.
assign qLastAdrs = (rAdrs == {`MT_ADRS_WIDTH{1'b1}});
assign qReadAck = (rState == stRead) && wb.ack;

// expected word, also the write data.
assign qPattern = rBase + memWord'(rAdrs);


// ~~~~~~~~~~~~~~~~~~~~
// sequencer
// ~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge iCLK)
begin
	if (iRST)
	begin
		rState <= stIdle;
		rAdrs <= `MT_ADRS_RST;
		rStb <= 1'b0;
	end
	else
	begin
		case (rState)
			stIdle:
			begin
				if (start)
					rState <= stWrite;
				rAdrs <= `MT_ADRS_RST;
				rStb <= 1'b0;
			end

			stWrite, stRead:
			begin
				// stb rises on the cycle after a low one, so transfers never touch.
				if (!rStb)
					rStb <= 1'b1;
				else if (wb.ack)
				begin
					rStb <= 1'b0;
					rAdrs <= rAdrs + 1'b1;		// wraps to zero for the next pass.
					if (qLastAdrs)
						rState <= (rState == stWrite) ? stRead : stDone;
				end
			end

			stDone:
				rState <= stIdle;

			default:
				rState <= stIdle;
		endcase
	end
end

// base is held for the whole run.
always_ff @(posedge iCLK)
begin
	if (qAccept)
		rBase <= patternBase;
end


// ~~~~~~~~~~~~~~~~~~~~
// comparator and error log
// ~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge iCLK)
begin
	if (iRST || qAccept)
	begin
		error <= 1'b0;
		errCount <= {`MT_ERRCNT_WIDTH{1'b0}};
		firstErrAdrs <= `MT_ADRS_RST;
		firstErrData <= `MT_DATA_RST;
	end
	else if (qReadAck && (wb.datR != qPattern))
	begin
		error <= 1'b1;
		errCount <= errCount + 1'b1;
		if (!error)
		begin
			// only the first mismatch is kept.
			firstErrAdrs <= rAdrs;
			firstErrData <= wb.datR;
		end
	end
end

assign wb.cyc = rStb;
assign wb.stb = rStb;
assign wb.we = (rState == stWrite);
assign wb.adr = rAdrs;
assign wb.datW = qPattern;

assign busy = (rState == stWrite) || (rState == stRead);
assign done = (rState == stDone);		// busy is already low here.

endmodule

/* hdl/sram_array.sv */
`timescale 1ns/10ps
// ~~~~~~~~~~~~~~~~~~~~
// word storage with registered read port.
// one address can be made to store corrupted data.
// ~~~~~~~~~~~~~~~~~~~~
`include "memtest_params.svh"

module sram_array
	import memtest_pkg::*;
(
	input  logic iCLK,
	sramPort.mem mem,
	input  logic faultEn,
	input  memAdrs faultAdrs,
	input  memWord faultMask
);

localparam int lpDepth = 1 << `MT_ADRS_WIDTH;

memWord rMem [lpDepth];
memWord rRd;
memWord qFlip;

// bits to invert on the faulty cell.
assign qFlip = (faultEn && (mem.adrs == faultAdrs)) ? faultMask : '0;


// ~~~~~~~~~~~~~~~~~~~~
// write and read ports
// ~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge iCLK)
begin
	if (mem.op == opWrite)
		rMem[mem.adrs] <= mem.wd ^ qFlip;
end

always_ff @(posedge iCLK)
begin
	if (mem.op == opRead)
		rRd <= rMem[mem.adrs];		// valid one cycle after the op.
end

assign mem.rd = rRd;

endmodule

/* hdl/sram_controller.sv */
`timescale 1ns/10ps
// ~~~~~~~~~~~~~~~~~~~~
// wishbone classic slave for the storage array.
// inserts wait states, then one storage op and ack.
// ~~~~~~~~~~~~~~~~~~~~
`include "memtest_params.svh"

module sram_controller
	import memtest_pkg::*;
(
	input  logic iCLK,
	input  logic iRST,
	wbBus.slave wb,
	sramPort.ctrl mem
);

// counter wide enough for the wait count, and never zero bits.
localparam int lpCntWidth = $clog2(`MT_WAIT_STATES + 2);
localparam logic [lpCntWidth-1:0] lpWaitLast = lpCntWidth'(`MT_WAIT_STATES);

ctrlState rState;
logic [lpCntWidth-1:0] rWaitCnt;
logic qAck;


// ~~~~~~~~~~~~~~~~~~~~
// cycle sequencer
// ~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge iCLK)
begin
	if (iRST)
	begin
		rState <= csIdle;
		rWaitCnt <= '0;
	end
	else
	begin
		case (rState)
			csIdle:
			begin
				if (wb.cyc && wb.stb)
				begin
					// zero wait states go straight to the access.
					rState <= (lpWaitLast == '0) ? csAccess : csWait;
				end
				rWaitCnt <= lpCntWidth'(1);
			end

			csWait:
			begin
				if (rWaitCnt == lpWaitLast)
					rState <= csAccess;
				else
					rWaitCnt <= rWaitCnt + 1'b1;
			end

			csAccess:
				rState <= csAck;		// read data lands on rd now.

			csAck:
				rState <= csIdle;		// master drops stb meanwhile.

			default:
				rState <= csIdle;
		endcase
	end
end


// ~~~~~~~~~~~~~~~~~~~~
// storage command and bus response
// ~~~~~~~~~~~~~~~~~~~~
always_comb
begin
	mem.op = opNop;
	if (rState == csAccess)
		mem.op = wb.we ? opWrite : opRead;
end

// master holds address and data stable until ack.
assign mem.adrs = wb.adr;
assign mem.wd = wb.datW;

assign qAck = (rState == csAck);
assign wb.ack = qAck;
assign wb.datR = qAck ? mem.rd : '0;

endmodule
